//--- design/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::alu_op_t         alu_op,
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    output logic [rv_pkg::xlen-1:0] result
);
    logic [4:0] shamt;

    // Shift amount from the low five bits only
    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            rv_pkg::alu_add: begin
                result = a + b;
            end
            rv_pkg::alu_sub: begin
                result = a - b;
            end
            rv_pkg::alu_sll: begin
                result = a << shamt;
            end
            rv_pkg::alu_slt: begin
                result = {{(rv_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            end
            rv_pkg::alu_sltu: begin
                result = {{(rv_pkg::xlen-1){1'b0}}, a < b};
            end
            rv_pkg::alu_xor: begin
                result = a ^ b;
            end
            rv_pkg::alu_srl: begin
                result = a >> shamt;
            end
            rv_pkg::alu_sra: begin
                result = $unsigned($signed(a) >>> shamt);
            end
            rv_pkg::alu_or: begin
                result = a | b;
            end
            rv_pkg::alu_and: begin
                result = a & b;
            end
            rv_pkg::alu_pass_b: begin
                // lui
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             imem_data,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    output logic [3:0]              dmem_wstrb,
    output logic                    dmem_we,
    output logic                    halted,
    output logic                    illegal
);
    logic [rv_pkg::reg_addr_w-1:0] rs1, rs2, rd;
    logic                          rd_we;
    logic [31:0]                   imm;
    rv_pkg::alu_op_t               alu_op;
    logic                          src_a_pc, src_b_imm;
    rv_pkg::br_cond_t              br_cond;
    logic                          is_jal, is_jalr;
    logic                          mem_read, mem_write, mem_unsigned;
    rv_pkg::mem_size_t             mem_size;
    rv_pkg::wb_sel_t               wb_sel;
    logic                          is_ebreak, is_illegal;
    logic [rv_pkg::xlen-1:0]       rs1_data, rs2_data;
    logic [rv_pkg::xlen-1:0]       alu_a, alu_b, alu_result;
    logic [rv_pkg::xlen-1:0]       pc, pc_plus4;
    logic [rv_pkg::xlen-1:0]       load_data, wb_data;

    assign imem_addr = pc;

    rv_decode u_decode (
        .instr(imem_data), .rs1(rs1), .rs2(rs2), .rd(rd), .rd_we(rd_we), .imm(imm),
        .alu_op(alu_op), .src_a_pc(src_a_pc), .src_b_imm(src_b_imm), .br_cond(br_cond),
        .is_jal(is_jal), .is_jalr(is_jalr), .mem_read(mem_read), .mem_write(mem_write),
        .mem_unsigned(mem_unsigned), .mem_size(mem_size), .wb_sel(wb_sel),
        .is_ebreak(is_ebreak), .is_illegal(is_illegal)
    );

    // No register writes once halted
    rv_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd), .rd_we(rd_we && !halted),
        .rd_data(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    assign alu_a = src_a_pc ? pc : rs1_data;
    assign alu_b = src_b_imm ? imm : rs2_data;

    rv_alu u_alu (.alu_op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result));

    rv_pc_unit #(.reset_pc(reset_pc)) u_pc_unit (
        .clk(clk), .rst_n(rst_n), .br_cond(br_cond), .is_jal(is_jal), .is_jalr(is_jalr),
        .halt_req(is_ebreak || is_illegal), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .imm(imm), .pc(pc), .pc_plus4(pc_plus4), .halted(halted)
    );

    rv_lsu u_lsu (
        .addr(alu_result), .store_data(rs2_data), .mem_read(mem_read), .mem_write(mem_write),
        .mem_size(mem_size), .mem_unsigned(mem_unsigned), .halted(halted),
        .dmem_rdata(dmem_rdata), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_wstrb(dmem_wstrb), .dmem_we(dmem_we), .load_data(load_data)
    );

    // Writeback select
    always_comb begin
        case (wb_sel)
            rv_pkg::wb_mem:      wb_data = load_data;
            rv_pkg::wb_pc_plus4: wb_data = pc_plus4;
            default:             wb_data = alu_result;
        endcase
    end

    // Sticky, rises together with halted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            illegal <= 1'b0;
        end else if (is_illegal) begin
            illegal <= 1'b1;
        end
    end

endmodule

//--- design/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic [31:0]                   instr,
    output logic [rv_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::reg_addr_w-1:0] rd,
    output logic                          rd_we,
    output logic [31:0]                   imm,
    output rv_pkg::alu_op_t               alu_op,
    output logic                          src_a_pc,
    output logic                          src_b_imm,
    output rv_pkg::br_cond_t              br_cond,
    output logic                          is_jal,
    output logic                          is_jalr,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic                          mem_unsigned,
    output rv_pkg::mem_size_t             mem_size,
    output rv_pkg::wb_sel_t               wb_sel,
    output logic                          is_ebreak,
    output logic                          is_illegal
);
    logic [4:0]  opcode;
    logic [2:0]  funct3;
    logic        f7_zero;
    logic        f7_alt;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    // funct3 to ALU operation, alt selects sub or sra
    function automatic rv_pkg::alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  return rv_pkg::alu_sll;
            3'b010:  return rv_pkg::alu_slt;
            3'b011:  return rv_pkg::alu_sltu;
            3'b100:  return rv_pkg::alu_xor;
            3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  return rv_pkg::alu_or;
            default: return rv_pkg::alu_and;
        endcase
    endfunction

    assign opcode  = instr[6:2];
    assign funct3  = instr[14:12];
    assign f7_zero = instr[31:25] == 7'b0000000;
    assign f7_alt  = instr[31:25] == 7'b0100000;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // Sign-extended immediates per format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        rd_we        = 1'b0;
        imm          = '0;
        alu_op       = rv_pkg::alu_add;
        src_a_pc     = 1'b0;
        src_b_imm    = 1'b0;
        br_cond      = rv_pkg::br_none;
        is_jal       = 1'b0;
        is_jalr      = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_unsigned = funct3[2];
        mem_size     = rv_pkg::mem_size_t'(funct3[1:0]);
        wb_sel       = rv_pkg::wb_alu;
        is_ebreak    = 1'b0;
        is_illegal   = 1'b0;
        case (opcode)
            rv_pkg::op_load: begin
                rd_we      = 1'b1;
                imm        = imm_i;
                src_b_imm  = 1'b1;
                mem_read   = 1'b1;
                wb_sel     = rv_pkg::wb_mem;
                is_illegal = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
            end
            rv_pkg::op_store: begin
                imm        = imm_s;
                src_b_imm  = 1'b1;
                mem_write  = 1'b1;
                is_illegal = funct3[2] || (funct3[1:0] == 2'b11);
            end
            rv_pkg::op_imm: begin
                rd_we     = 1'b1;
                imm       = imm_i;
                src_b_imm = 1'b1;
                alu_op    = alu_from_funct(funct3, (funct3 == 3'b101) && f7_alt);
                if (funct3 == 3'b001) begin
                    is_illegal = !f7_zero;
                end else if (funct3 == 3'b101) begin
                    is_illegal = !(f7_zero || f7_alt);
                end
            end
            rv_pkg::op_reg: begin
                rd_we      = 1'b1;
                alu_op     = alu_from_funct(funct3, f7_alt);
                is_illegal = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            rv_pkg::op_branch: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  br_cond = rv_pkg::br_eq;
                    3'b001:  br_cond = rv_pkg::br_ne;
                    3'b100:  br_cond = rv_pkg::br_lt;
                    3'b101:  br_cond = rv_pkg::br_ge;
                    3'b110:  br_cond = rv_pkg::br_ltu;
                    3'b111:  br_cond = rv_pkg::br_geu;
                    default: is_illegal = 1'b1;
                endcase
            end
            rv_pkg::op_jal: begin
                rd_we  = 1'b1;
                imm    = imm_j;
                is_jal = 1'b1;
                wb_sel = rv_pkg::wb_pc_plus4;
            end
            rv_pkg::op_jalr: begin
                rd_we      = 1'b1;
                imm        = imm_i;
                is_jalr    = 1'b1;
                wb_sel     = rv_pkg::wb_pc_plus4;
                is_illegal = funct3 != 3'b000;
            end
            rv_pkg::op_lui: begin
                rd_we     = 1'b1;
                imm       = imm_u;
                src_b_imm = 1'b1;
                alu_op    = rv_pkg::alu_pass_b;
            end
            rv_pkg::op_auipc: begin
                rd_we     = 1'b1;
                imm       = imm_u;
                src_a_pc  = 1'b1;
                src_b_imm = 1'b1;
            end
            rv_pkg::op_system: begin
                // CSR access, ecall and anything else here are not supported
                is_ebreak  = instr == rv_pkg::instr_ebreak;
                is_illegal = !is_ebreak;
            end
            default: is_illegal = 1'b1;
        endcase
        if (instr[1:0] != 2'b11) begin
            is_illegal = 1'b1;
        end
        // No side effects from an illegal word
        if (is_illegal) begin
            rd_we     = 1'b0;
            mem_read  = 1'b0;
            mem_write = 1'b0;
            is_jal    = 1'b0;
            is_jalr   = 1'b0;
            br_cond   = rv_pkg::br_none;
        end
        if (rd == '0) begin
            rd_we = 1'b0;
        end
    end

endmodule

//--- design/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
    input  logic [rv_pkg::xlen-1:0] addr,
    input  logic [rv_pkg::xlen-1:0] store_data,
    input  logic                    mem_read,
    input  logic                    mem_write,
    input  rv_pkg::mem_size_t       mem_size,
    input  logic                    mem_unsigned,
    input  logic                    halted,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    output logic [3:0]              dmem_wstrb,
    output logic                    dmem_we,
    output logic [rv_pkg::xlen-1:0] load_data
);
    logic [1:0]              lane;
    logic [3:0]              strb;
    logic [rv_pkg::xlen-1:0] lane_data;
    logic [rv_pkg::xlen-1:0] ext_data;

    assign lane      = addr[1:0];
    assign dmem_addr = {addr[rv_pkg::xlen-1:2], 2'b00};

    // Store data repeated on every lane, strobes pick the target bytes
    always_comb begin
        case (mem_size)
            rv_pkg::mem_byte: begin
                dmem_wdata = {4{store_data[7:0]}};
                strb       = 4'b0001 << lane;
            end
            rv_pkg::mem_half: begin
                dmem_wdata = {2{store_data[15:0]}};
                strb       = 4'b0011 << {lane[1], 1'b0};
            end
            default: begin
                dmem_wdata = store_data;
                strb       = 4'b1111;
            end
        endcase
    end

    assign dmem_we    = mem_write && !halted;
    assign dmem_wstrb = dmem_we ? strb : 4'b0000;

    // Addressed lane moved down to bit 0
    assign lane_data = dmem_rdata >> {lane, 3'b000};

    always_comb begin
        case (mem_size)
            rv_pkg::mem_byte: ext_data = {{24{!mem_unsigned && lane_data[7]}}, lane_data[7:0]};
            rv_pkg::mem_half: ext_data = {{16{!mem_unsigned && lane_data[15]}}, lane_data[15:0]};
            default:          ext_data = lane_data;
        endcase
    end

    assign load_data = mem_read ? ext_data : '0;

endmodule

//--- design/rv_pc_unit.sv
`timescale 1ns/1ps

module rv_pc_unit #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_pkg::br_cond_t        br_cond,
    input  logic                    is_jal,
    input  logic                    is_jalr,
    input  logic                    halt_req,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    input  logic [rv_pkg::xlen-1:0] imm,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] pc_plus4,
    output logic                    halted
);
    logic                    taken;
    logic [rv_pkg::xlen-1:0] pc_target;
    logic [rv_pkg::xlen-1:0] jalr_sum;
    logic [rv_pkg::xlen-1:0] next_pc;

    // Branch comparison
    always_comb begin
        case (br_cond)
            rv_pkg::br_eq:  taken = rs1_data == rs2_data;
            rv_pkg::br_ne:  taken = rs1_data != rs2_data;
            rv_pkg::br_lt:  taken = $signed(rs1_data) < $signed(rs2_data);
            rv_pkg::br_ge:  taken = $signed(rs1_data) >= $signed(rs2_data);
            rv_pkg::br_ltu: taken = rs1_data < rs2_data;
            rv_pkg::br_geu: taken = rs1_data >= rs2_data;
            default:        taken = 1'b0;
        endcase
    end

    assign pc_plus4  = pc + 'd4;
    assign pc_target = pc + imm;
    assign jalr_sum  = rs1_data + imm;

    always_comb begin
        if (halted || halt_req) begin
            // Stay on the halting instruction
            next_pc = pc;
        end else if (is_jalr) begin
            next_pc = {jalr_sum[rv_pkg::xlen-1:1], 1'b0};
        end else if (is_jal || taken) begin
            next_pc = pc_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else begin
            pc <= next_pc;
            if (halt_req) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

//--- design/rv_pkg.sv
package rv_pkg;

    // Datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Major opcodes, instruction bits 6 to 2
    localparam logic [4:0] op_load   = 5'b00000;
    localparam logic [4:0] op_store  = 5'b01000;
    localparam logic [4:0] op_imm    = 5'b00100;
    localparam logic [4:0] op_reg    = 5'b01100;
    localparam logic [4:0] op_branch = 5'b11000;
    localparam logic [4:0] op_jal    = 5'b11011;
    localparam logic [4:0] op_jalr   = 5'b11001;
    localparam logic [4:0] op_lui    = 5'b01101;
    localparam logic [4:0] op_auipc  = 5'b00101;
    localparam logic [4:0] op_system = 5'b11100;

    // Only system instruction that is executed
    localparam logic [31:0] instr_ebreak = 32'h0010_0073;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu
    } br_cond_t;

    // Encoding matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        mem_byte = 2'b00,
        mem_half = 2'b01,
        mem_word = 2'b10
    } mem_size_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc_plus4
    } wb_sel_t;

endpackage

//--- design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    input  logic [rv_pkg::reg_addr_w-1:0] rd,
    input  logic                          rd_we,
    input  logic [rv_pkg::xlen-1:0]       rd_data,
    output logic [rv_pkg::xlen-1:0]       rs1_data,
    output logic [rv_pkg::xlen-1:0]       rs2_data
);
    localparam int depth = 2 ** rv_pkg::reg_addr_w;

    // x0 has no storage
    logic [rv_pkg::xlen-1:0] regs [1:depth-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- project.f
design/rv_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_pc_unit.sv
design/rv_lsu.sv
design/rv_core.sv
tb/rv_core_properties.sv
tb/rv_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module rv_core_tb -Mdir obj_dir -f project.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vrv_core_tb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" <<< "$output"; then
    exit 0
fi
exit 1

//--- tb/rv_core_properties.sv
`timescale 1ns/1ps

module rv_core_properties #(
    parameter logic [31:0] reset_pc = '0
) (
    input logic        clk,
    input logic        rst_n,
    input logic [31:0] imem_addr,
    input logic [3:0]  dmem_wstrb,
    input logic        dmem_we,
    input logic        halted,
    input logic        illegal
);
    int unsigned fail_count = 0;

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_addr[1:0] == 2'b00)
        else begin
            $error("imem_addr is not word aligned");
            fail_count++;
        end

    write_has_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we |-> dmem_wstrb != 4'b0000)
        else begin
            $error("dmem_we without any byte strobe");
            fail_count++;
        end

    // Halt is final until the next reset
    halt_holds: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted && $stable(imem_addr))
        else begin
            $error("PC or halted changed after halting");
            fail_count++;
        end

    halt_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !dmem_we)
        else begin
            $error("store issued while halted");
            fail_count++;
        end

    illegal_halts: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> halted)
        else begin
            $error("illegal set without halted");
            fail_count++;
        end

    reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> imem_addr == reset_pc && !halted && !illegal)
        else begin
            $error("core not in its reset state after reset release");
            fail_count++;
        end

endmodule

bind rv_core rv_core_properties #(.reset_pc(reset_pc)) u_props (
    .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .dmem_wstrb(dmem_wstrb),
    .dmem_we(dmem_we), .halted(halted), .illegal(illegal)
);

//--- tb/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
    localparam logic [31:0] reset_pc = 32'h0000_0040;
    localparam logic [31:0] res_base = 32'h0000_0100;
    localparam int rounds = 3;
    localparam int halt_limit = 2000;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic [31:0] imem_data;
    logic [31:0] dmem_rdata;
    logic [31:0] imem_addr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_wstrb;
    logic        dmem_we;
    logic        halted;
    logic        illegal;
    logic [31:0] imem [0:1023];
    logic [31:0] dmem [0:255];
    logic [31:0] expect_q [$];
    int          pc_idx;
    int          errors = 0;

    always #4 clk = ~clk;

    rv_core #(.reset_pc(reset_pc)) uut (
        .clk(clk), .rst_n(rst_n), .imem_data(imem_data), .dmem_rdata(dmem_rdata),
        .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_wstrb(dmem_wstrb), .dmem_we(dmem_we), .halted(halted), .illegal(illegal)
    );

    // Both memories answer in the same cycle
    assign imem_data  = imem[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_wstrb[i]) begin
                    dmem[dmem_addr[9:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] fill_word(input int idx);
        return 32'hd00d_0000 + 32'(idx);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg, 2'b11};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] op);
        return {imm, rs1, f3, rd, op, 2'b11};
    endfunction

    // Stores are always based on x0
    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], rv_pkg::op_store, 2'b11};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch, 2'b11};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [4:0] op);
        return {imm, rd, op, 2'b11};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::op_jal, 2'b11};
    endfunction

    // RV32I integer rules with alt taken from instruction bit 30
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] sign_fill;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'h0, $signed(a) < $signed(b)};
            3'd3: return {31'h0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                // Vacated high bits take the sign for sra
                sign_fill = alt ? ~(32'hffff_ffff >> b[4:0]) & {32{a[31]}} : 32'h0;
                return (a >> b[4:0]) | sign_fill;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[10'(pc_idx)] = word;
        pc_idx++;
    endtask

    task automatic store_result(input logic [4:0] rs, input logic [31:0] value);
        emit(enc_s(12'(res_base + 32'(4 * expect_q.size())), rs, 3'b010));
        expect_q.push_back(value);
    endtask

    task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        emit(enc_u(upper[31:12], rd, rv_pkg::op_lui));
        emit(enc_i(value[11:0], rd, 3'b000, rd, rv_pkg::op_imm));
    endtask

    task automatic load_check(input logic [11:0] addr, input logic [2:0] f3,
                              input logic [31:0] value);
        emit(enc_i(addr, 5'd0, f3, 5'd5, rv_pkg::op_load));
        store_result(5'd5, value);
    endtask

    task automatic alu_round(input logic [31:0] a, input logic [31:0] b);
        logic [11:0] imm;
        set_reg(5'd1, a);
        set_reg(5'd2, b);
        for (int f = 0; f < 8; f++) begin
            for (int s = 0; s < 2; s++) begin
                if (s == 0 || f == 0 || f == 5) begin
                    emit(enc_r(s == 1 ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(f), 5'd3));
                    store_result(5'd3, alu_ref(3'(f), s == 1, a, b));
                end
                if (s == 0 || f == 5) begin
                    imm = 12'($urandom);
                    if (f == 1 || f == 5) begin
                        imm = {s == 1 ? 7'h20 : 7'h00, imm[4:0]};
                    end
                    emit(enc_i(imm, 5'd1, 3'(f), 5'd4, rv_pkg::op_imm));
                    store_result(5'd4, alu_ref(3'(f), s == 1, a, {{20{imm[11]}}, imm}));
                end
            end
        end
    endtask

    task automatic mem_round(input logic [31:0] a, input logic [31:0] b);
        emit(enc_s(12'h080, 5'd1, 3'b010));
        emit(enc_s(12'h081, 5'd2, 3'b000));
        emit(enc_s(12'h084, 5'd1, 3'b010));
        emit(enc_s(12'h086, 5'd2, 3'b001));
        load_check(12'h080, 3'b010, {a[31:16], b[7:0], a[7:0]});
        load_check(12'h081, 3'b000, {{24{b[7]}}, b[7:0]});
        load_check(12'h081, 3'b100, {24'h0, b[7:0]});
        load_check(12'h083, 3'b000, {{24{a[31]}}, a[31:24]});
        load_check(12'h086, 3'b001, {{16{b[15]}}, b[15:0]});
        load_check(12'h086, 3'b101, {16'h0, b[15:0]});
        load_check(12'h084, 3'b001, {{16{a[15]}}, a[15:0]});
        load_check(12'h084, 3'b010, {b[15:0], a[15:0]});
    endtask

    // Marker in x6 is 1 when the branch skips the clear
    task automatic branch_round(input logic [31:0] a, input logic [31:0] b);
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                for (int r = 1; r <= 2; r++) begin
                    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd6, rv_pkg::op_imm));
                    emit(enc_b(13'd8, 5'(r), 5'd1, 3'(f)));
                    emit(enc_i(12'd0, 5'd0, 3'b000, 5'd6, rv_pkg::op_imm));
                    store_result(5'd6, {31'h0, branch_ref(3'(f), a, r == 1 ? a : b)});
                end
            end
        end
    endtask

    task automatic jump_upper_round();
        logic [31:0] target;
        logic [19:0] u;
        emit(enc_j(21'd8, 5'd7));
        emit(enc_i(12'd0, 5'd0, 3'b000, 5'd7, rv_pkg::op_imm));
        store_result(5'd7, 32'(pc_idx - 1) << 2);
        // Odd jalr sum so bit 0 must be dropped
        target = 32'(pc_idx + 3) << 2;
        emit(enc_i(12'(target - 32'd8), 5'd0, 3'b000, 5'd6, rv_pkg::op_imm));
        emit(enc_i(12'd9, 5'd6, 3'b000, 5'd7, rv_pkg::op_jalr));
        emit(enc_i(12'd0, 5'd0, 3'b000, 5'd7, rv_pkg::op_imm));
        store_result(5'd7, target - 32'd4);
        u = 20'($urandom);
        emit(enc_u(u, 5'd8, rv_pkg::op_lui));
        store_result(5'd8, {u, 12'h0});
        emit(enc_u(u, 5'd9, rv_pkg::op_auipc));
        store_result(5'd9, {u, 12'h0} + (32'(pc_idx - 1) << 2));
        emit(enc_i(12'h7ff, 5'd1, 3'b000, 5'd0, rv_pkg::op_imm));
        emit(enc_u(u, 5'd0, rv_pkg::op_lui));
        store_result(5'd0, 32'h0);
    endtask

    task automatic start_program();
        @(negedge clk);
        rst_n = 1'b0;
        // Unwritten instruction words have low bits 00 and decode as illegal
        for (int i = 0; i < 1024; i++) begin
            imem[10'(i)] = 32'(i) << 2;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[8'(i)] <= fill_word(i);
        end
        expect_q.delete();
        pc_idx = int'(reset_pc >> 2);
    endtask

    task automatic run_program();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < halt_limit && !halted; n++) begin
            @(negedge clk);
        end
        if (!halted) begin
            $display("timeout: the core did not halt within %0d cycles", halt_limit);
            $display("TB FAILED");
            $finish;
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic check_results();
        int word;
        for (int i = 0; i < expect_q.size(); i++) begin
            word = int'(res_base >> 2) + i;
            assert (dmem[8'(word)] === expect_q[i]) else begin
                errors++;
                $display("error dmem[%h] = %h, expected %h", word << 2, dmem[8'(word)],
                         expect_q[i]);
            end
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        void'($urandom(13));
        start_program();
        for (int r = 0; r < rounds; r++) begin
            a = $urandom;
            b = $urandom;
            alu_round(a, b);
            mem_round(a, b);
            branch_round(a, b);
            jump_upper_round();
        end
        emit(rv_pkg::instr_ebreak);
        run_program();
        assert (!illegal) else begin
            errors++;
            $display("ebreak raised the illegal flag");
        end
        check_results();

        // csrrw on mstatus followed by a store that must never happen
        start_program();
        set_reg(5'd1, 32'h55);
        store_result(5'd1, 32'h55);
        emit({12'h300, 5'd1, 3'b001, 5'd0, rv_pkg::op_system, 2'b11});
        store_result(5'd1, fill_word(int'(res_base >> 2) + 1));
        emit(rv_pkg::instr_ebreak);
        run_program();
        assert (illegal && halted) else begin
            errors++;
            $display("error illegal = %h, halted = %h, expected 1 and 1", illegal, halted);
        end
        check_results();

        $display("check errors: %0d, property errors: %0d", errors, uut.u_props.fail_count);
        if (errors == 0 && uut.u_props.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
